//--- source/ao_periph_pkg.sv
/* Widths, address map and register request types of the always-on subsystem.
   Regions are 256 bytes, selected by address bits 11:8; peripherals decode bits 7:0 only */
package ao_periph_pkg;

  localparam int unsigned AO_ADDR_W = 32;
  localparam int unsigned AO_DATA_W = 32;

  localparam logic [AO_ADDR_W-1:0] SOC_CTRL_BASE = 32'h0000_0000;
  localparam logic [AO_ADDR_W-1:0] TIMER_BASE    = 32'h0000_0100;
  localparam logic [AO_ADDR_W-1:0] GPIO_BASE     = 32'h0000_0200;

  typedef enum logic [1:0] {
    SLV_SOC_CTRL,
    SLV_TIMER,
    SLV_GPIO,
    SLV_NONE
  } ao_slave_e;

  typedef enum logic [7:0] {
    REG_EXIT_VALID = 8'h00,
    REG_EXIT_VALUE = 8'h04,
    REG_BOOT_SEL   = 8'h08,
    REG_SCRATCH    = 8'h0C
  } soc_ctrl_reg_e;

  typedef enum logic [7:0] {
    REG_TCTRL    = 8'h00,
    REG_TCOUNT   = 8'h04,
    REG_TCOMPARE = 8'h08,
    REG_TSTATUS  = 8'h0C
  } timer_reg_e;

  typedef enum logic [7:0] {
    REG_GOUT = 8'h00,
    REG_GDIR = 8'h04,
    REG_GIN  = 8'h08,
    REG_GIE  = 8'h0C,
    REG_GIS  = 8'h10
  } gpio_reg_e;

  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [AO_ADDR_W-1:0] addr;
    logic [AO_DATA_W-1:0] wdata;
    logic [3:0]           wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [AO_DATA_W-1:0] rdata;
    logic                 error;
  } reg_rsp_t;

  // Byte strobes expanded to a bit mask
  function automatic logic [AO_DATA_W-1:0] strb_to_mask(input logic [3:0] strb);
    logic [AO_DATA_W-1:0] mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

endpackage : ao_periph_pkg

//--- source/wb_to_reg.sv
/* Wishbone classic slave, single accesses only. Every access is acknowledged
   one cycle after it is first seen; no wait states, no pipelined or burst cycles */
module wb_to_reg
  import ao_periph_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [AO_ADDR_W-1:0] wb_adr_i,
  input  logic [AO_DATA_W-1:0] wb_dat_i,
  input  logic [3:0]           wb_sel_i,
  output logic [AO_DATA_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output reg_req_t             reg_req_o,
  input  reg_rsp_t             reg_rsp_i
);

  logic                 ack_q;
  logic                 err_q;
  logic [AO_DATA_W-1:0] rdata_q;
  logic                 req_valid;

  // No re-issue while the response of this access is on the bus
  assign req_valid = wb_cyc_i && wb_stb_i && !(ack_q || err_q);

  assign reg_req_o.valid = req_valid;
  assign reg_req_o.write = wb_we_i;
  assign reg_req_o.addr  = wb_adr_i;
  assign reg_req_o.wdata = wb_dat_i;
  assign reg_req_o.wstrb = wb_sel_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_valid && !reg_rsp_i.error;
      err_q <= req_valid && reg_rsp_i.error;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid) begin
      rdata_q <= reg_rsp_i.rdata;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;
  assign wb_dat_o = rdata_q;

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ack_q && err_q));

  // Master keeps cyc up until it has seen the response
  a_rsp_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ack_q || err_q) |-> wb_cyc_i);

endmodule : wb_to_reg

//--- source/reg_demux.sv
/* Routes a register request to one peripheral by address bits 11:8.
   Anything outside the three regions, including nonzero bits above 11, errors */
module reg_demux
  import ao_periph_pkg::*;
(
  input  reg_req_t req_i,
  output reg_rsp_t rsp_o,
  output reg_req_t soc_req_o,
  output reg_req_t tmr_req_o,
  output reg_req_t gpio_req_o,
  input  reg_rsp_t soc_rsp_i,
  input  reg_rsp_t tmr_rsp_i,
  input  reg_rsp_t gpio_rsp_i
);

  ao_slave_e slv_sel;

  always_comb begin
    if (req_i.addr[AO_ADDR_W-1:12] != '0) begin
      slv_sel = SLV_NONE;
    end else begin
      case (req_i.addr[11:8])
        SOC_CTRL_BASE[11:8]: slv_sel = SLV_SOC_CTRL;
        TIMER_BASE[11:8]:    slv_sel = SLV_TIMER;
        GPIO_BASE[11:8]:     slv_sel = SLV_GPIO;
        default:             slv_sel = SLV_NONE;
      endcase
    end
  end

  always_comb begin
    soc_req_o        = req_i;
    tmr_req_o        = req_i;
    gpio_req_o       = req_i;
    soc_req_o.valid  = req_i.valid && (slv_sel == SLV_SOC_CTRL);
    tmr_req_o.valid  = req_i.valid && (slv_sel == SLV_TIMER);
    gpio_req_o.valid = req_i.valid && (slv_sel == SLV_GPIO);
  end

  always_comb begin
    case (slv_sel)
      SLV_SOC_CTRL: rsp_o = soc_rsp_i;
      SLV_TIMER:    rsp_o = tmr_rsp_i;
      SLV_GPIO:     rsp_o = gpio_rsp_i;
      default: begin
        rsp_o.rdata = '0;
        rsp_o.error = 1'b1;
      end
    endcase
  end

  // Single target per request
  always_comb begin
    a_one_valid: assert ($onehot0({soc_req_o.valid, tmr_req_o.valid, gpio_req_o.valid}));
  end

endmodule : reg_demux

//--- source/soc_ctrl.sv
/* SoC control registers. exit_valid_o is sticky until reset; boot_select_i
   is sampled every cycle, so readback lags the pin by one cycle */
module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  reg_req_t             reg_req_i,
  output reg_rsp_t             reg_rsp_o,
  input  logic                 boot_select_i,
  output logic                 exit_valid_o,
  output logic [AO_DATA_W-1:0] exit_value_o
);

  logic                 exit_valid_q;
  logic [AO_DATA_W-1:0] exit_value_q;
  logic [AO_DATA_W-1:0] scratch_q;
  logic                 boot_sel_q;
  logic                 wr;
  logic [AO_DATA_W-1:0] wmask;
  logic [7:0]           offset;

  assign wr     = reg_req_i.valid && reg_req_i.write;
  assign wmask  = strb_to_mask(reg_req_i.wstrb);
  assign offset = reg_req_i.addr[7:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
      boot_sel_q   <= 1'b0;
    end else begin
      boot_sel_q <= boot_select_i;
      if (wr) begin
        case (offset)
          REG_EXIT_VALID: begin
            // Only a one sticks
            if (reg_req_i.wdata[0] && wmask[0]) begin
              exit_valid_q <= 1'b1;
            end
          end
          REG_EXIT_VALUE: exit_value_q <= (exit_value_q & ~wmask) | (reg_req_i.wdata & wmask);
          REG_SCRATCH:    scratch_q <= (scratch_q & ~wmask) | (reg_req_i.wdata & wmask);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      REG_EXIT_VALID: reg_rsp_o.rdata = {{(AO_DATA_W-1){1'b0}}, exit_valid_q};
      REG_EXIT_VALUE: reg_rsp_o.rdata = exit_value_q;
      REG_BOOT_SEL:   reg_rsp_o.rdata = {{(AO_DATA_W-1){1'b0}}, boot_sel_q};
      REG_SCRATCH:    reg_rsp_o.rdata = scratch_q;
      default:        reg_rsp_o.rdata = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

//--- source/ao_timer.sv
/* 32-bit up-counter, reloads to zero on the edge where it matches compare.
   A bus write to the count wins over the increment; a new expiry wins over a clear */
module ao_timer
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     timer_intr_o
);

  logic [1:0]           ctrl_q;
  logic [AO_DATA_W-1:0] count_q;
  logic [AO_DATA_W-1:0] compare_q;
  logic                 expired_q;
  logic                 wr;
  logic [AO_DATA_W-1:0] wmask;
  logic [7:0]           offset;
  logic                 cnt_wr;
  logic                 cmp_wr;
  logic                 match;

  assign wr     = reg_req_i.valid && reg_req_i.write;
  assign wmask  = strb_to_mask(reg_req_i.wstrb);
  assign offset = reg_req_i.addr[7:0];
  assign cnt_wr = wr && (offset == REG_TCOUNT);
  assign cmp_wr = wr && (offset == REG_TCOMPARE);
  assign match  = ctrl_q[0] && (count_q == compare_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q    <= '0;
      count_q   <= '0;
      compare_q <= '0;
      expired_q <= 1'b0;
    end else begin
      if (wr && (offset == REG_TCTRL)) begin
        ctrl_q <= (ctrl_q & ~wmask[1:0]) | (reg_req_i.wdata[1:0] & wmask[1:0]);
      end
      if (cmp_wr) begin
        compare_q <= (compare_q & ~wmask) | (reg_req_i.wdata & wmask);
      end
      if (cnt_wr) begin
        count_q <= (count_q & ~wmask) | (reg_req_i.wdata & wmask);
      end else if (match) begin
        count_q <= '0;
      end else if (ctrl_q[0]) begin
        count_q <= count_q + 1'b1;
      end
      if (wr && (offset == REG_TSTATUS) && reg_req_i.wdata[0] && wmask[0]) begin
        expired_q <= 1'b0;
      end
      if (match) begin
        expired_q <= 1'b1;
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      REG_TCTRL:    reg_rsp_o.rdata = {{(AO_DATA_W-2){1'b0}}, ctrl_q};
      REG_TCOUNT:   reg_rsp_o.rdata = count_q;
      REG_TCOMPARE: reg_rsp_o.rdata = compare_q;
      REG_TSTATUS:  reg_rsp_o.rdata = {{(AO_DATA_W-1){1'b0}}, expired_q};
      default:      reg_rsp_o.rdata = '0;
    endcase
  end

  assign timer_intr_o = expired_q && ctrl_q[1];

  // Once in range the running counter stays there unless software moves count or compare
  a_count_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ctrl_q[0] && $past(ctrl_q[0]) && $past(count_q <= compare_q) &&
     !$past(cnt_wr || cmp_wr)) |-> (count_q <= compare_q));

endmodule : ao_timer

//--- source/gpio.sv
/* GPIO with output, direction and rising-edge interrupt registers.
   NUM_GPIO must be 1 to 32; inputs pass a two-flop synchroniser */
module gpio
  import ao_periph_pkg::*;
#(
  parameter int unsigned NUM_GPIO = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  reg_req_t            reg_req_i,
  output reg_rsp_t            reg_rsp_o,
  input  logic [NUM_GPIO-1:0] cio_gpio_i,
  output logic [NUM_GPIO-1:0] cio_gpio_o,
  output logic [NUM_GPIO-1:0] cio_gpio_en_o,
  output logic                intr_gpio_o
);

  logic [NUM_GPIO-1:0]  gout_q;
  logic [NUM_GPIO-1:0]  gdir_q;
  logic [NUM_GPIO-1:0]  gie_q;
  logic [NUM_GPIO-1:0]  gis_q;
  logic [NUM_GPIO-1:0]  sync1_q;
  logic [NUM_GPIO-1:0]  sync2_q;
  logic [NUM_GPIO-1:0]  prev_q;
  logic [NUM_GPIO-1:0]  rise;
  logic [NUM_GPIO-1:0]  wdata;
  logic [NUM_GPIO-1:0]  wmask;
  logic [AO_DATA_W-1:0] wmask_full;
  logic                 wr;
  logic [7:0]           offset;

  assign wr         = reg_req_i.valid && reg_req_i.write;
  assign offset     = reg_req_i.addr[7:0];
  assign wmask_full = strb_to_mask(reg_req_i.wstrb);
  assign wmask      = wmask_full[NUM_GPIO-1:0];
  assign wdata      = reg_req_i.wdata[NUM_GPIO-1:0];

  // Edge on the synchronised value
  assign rise = sync2_q & ~prev_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gout_q  <= '0;
      gdir_q  <= '0;
      gie_q   <= '0;
      gis_q   <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= cio_gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr && (offset == REG_GOUT)) gout_q <= (gout_q & ~wmask) | (wdata & wmask);
      if (wr && (offset == REG_GDIR)) gdir_q <= (gdir_q & ~wmask) | (wdata & wmask);
      if (wr && (offset == REG_GIE))  gie_q  <= (gie_q & ~wmask) | (wdata & wmask);
      if (wr && (offset == REG_GIS)) begin
        gis_q <= (gis_q & ~(wdata & wmask)) | rise;
      end else begin
        gis_q <= gis_q | rise;
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      REG_GOUT: reg_rsp_o.rdata = AO_DATA_W'(gout_q);
      REG_GDIR: reg_rsp_o.rdata = AO_DATA_W'(gdir_q);
      REG_GIN:  reg_rsp_o.rdata = AO_DATA_W'(sync2_q);
      REG_GIE:  reg_rsp_o.rdata = AO_DATA_W'(gie_q);
      REG_GIS:  reg_rsp_o.rdata = AO_DATA_W'(gis_q);
      default:  reg_rsp_o.rdata = '0;
    endcase
  end

  assign cio_gpio_o    = gout_q;
  assign cio_gpio_en_o = gdir_q;
  assign intr_gpio_o   = |(gis_q & gie_q);

endmodule : gpio

//--- source/ao_peripheral_subsystem.sv
/* Always-on peripheral subsystem: Wishbone slave to SoC control, timer and GPIO.
   Map: 0x000 SoC control, 0x100 timer, 0x200 GPIO; anything else returns err */
module ao_peripheral_subsystem
  import ao_periph_pkg::*;
#(
  parameter int unsigned NUM_GPIO = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [AO_ADDR_W-1:0] wb_adr_i,
  input  logic [AO_DATA_W-1:0] wb_dat_i,
  input  logic [3:0]           wb_sel_i,
  output logic [AO_DATA_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,

  input  logic                 boot_select_i,
  output logic                 exit_valid_o,
  output logic [AO_DATA_W-1:0] exit_value_o,

  output logic                 rv_timer_intr_o,

  input  logic [NUM_GPIO-1:0]  cio_gpio_i,
  output logic [NUM_GPIO-1:0]  cio_gpio_o,
  output logic [NUM_GPIO-1:0]  cio_gpio_en_o,
  output logic                 intr_gpio_o
);

  reg_req_t bus_req;
  reg_rsp_t bus_rsp;
  reg_req_t soc_req;
  reg_rsp_t soc_rsp;
  reg_req_t tmr_req;
  reg_rsp_t tmr_rsp;
  reg_req_t gpio_req;
  reg_rsp_t gpio_rsp;

  wb_to_reg wb_to_reg_i (
    .clk_i,
    .rst_n_i,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_sel_i,
    .wb_dat_o,
    .wb_ack_o,
    .wb_err_o,
    .reg_req_o(bus_req),
    .reg_rsp_i(bus_rsp)
  );

  reg_demux reg_demux_i (
    .req_i     (bus_req),
    .rsp_o     (bus_rsp),
    .soc_req_o (soc_req),
    .tmr_req_o (tmr_req),
    .gpio_req_o(gpio_req),
    .soc_rsp_i (soc_rsp),
    .tmr_rsp_i (tmr_rsp),
    .gpio_rsp_i(gpio_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(soc_req),
    .reg_rsp_o(soc_rsp),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  ao_timer ao_timer_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i   (tmr_req),
    .reg_rsp_o   (tmr_rsp),
    .timer_intr_o(rv_timer_intr_o)
  );

  gpio #(
    .NUM_GPIO(NUM_GPIO)
  ) gpio_ao_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(gpio_req),
    .reg_rsp_o(gpio_rsp),
    .cio_gpio_i,
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

endmodule : ao_peripheral_subsystem

//--- sim/tb_ao_peripheral_subsystem.sv
/* Testbench for the always-on subsystem with NUM_GPIO of 8.
   Single Wishbone classic cycles only; random data from a fixed-seed LFSR */
module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_GPIO   = 8;
  localparam int CLK_PERIOD = 40;
  localparam logic [31:0] GPIO_MASK = {{(32-NUM_GPIO){1'b0}}, {NUM_GPIO{1'b1}}};
  // About four cycles per bus access, plus margin
  localparam int WATCHDOG_CYCLES = 60 + 2000 + 150 + 60 + 300 + 120 + 500;

  logic                clk_i;
  logic                rst_n_i;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  logic [31:0]         wb_adr_i;
  logic [31:0]         wb_dat_i;
  logic [3:0]          wb_sel_i;
  logic [31:0]         wb_dat_o;
  logic                wb_ack_o;
  logic                wb_err_o;
  logic                boot_select_i;
  logic                exit_valid_o;
  logic [31:0]         exit_value_o;
  logic                rv_timer_intr_o;
  logic [NUM_GPIO-1:0] cio_gpio_i;
  logic [NUM_GPIO-1:0] cio_gpio_o;
  logic [NUM_GPIO-1:0] cio_gpio_en_o;
  logic                intr_gpio_o;

  logic [31:0] lfsr_q;
  logic [31:0] model [7];
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          errors_at_start;

  ao_peripheral_subsystem #(
    .NUM_GPIO(NUM_GPIO)
  ) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Byte lanes with their select bit set take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] sel);
    logic [31:0] v;
    v = old;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        v[8*i +: 8] = data[8*i +: 8];
      end
    end
    return v;
  endfunction

  // Read/write registers held in the model, last one unimplemented
  function automatic logic [31:0] reg_addr(input int idx);
    case (idx)
      0:       return SOC_CTRL_BASE + 32'(REG_SCRATCH);
      1:       return SOC_CTRL_BASE + 32'(REG_EXIT_VALUE);
      2:       return TIMER_BASE + 32'(REG_TCOMPARE);
      3:       return GPIO_BASE + 32'(REG_GOUT);
      4:       return GPIO_BASE + 32'(REG_GDIR);
      5:       return GPIO_BASE + 32'(REG_GIE);
      default: return SOC_CTRL_BASE + 32'h14;
    endcase
  endfunction

  function automatic logic [31:0] reg_mask(input int idx);
    if (idx < 3) begin
      return 32'hffff_ffff;
    end
    if (idx < 6) begin
      return GPIO_MASK;
    end
    return '0;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic ack, output logic err,
                           output logic [31:0] rdata);
    int n;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!wb_ack_o && !wb_err_o && n < 8);
    ack   = wb_ack_o;
    err   = wb_err_o;
    rdata = wb_dat_o;
    if (!ack && !err) begin
      errors++;
      $display("No ack or err within %0d cycles for address %h", n, adr);
    end else if (n != 2) begin
      errors++;
      $display("Response to address %h came %0d cycles after the request, not 1", adr, n - 1);
    end
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel, output logic ack, output logic err);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, sel, ack, err, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic ack, output logic err,
                         output logic [31:0] data);
    wb_access(1'b0, adr, 32'h0, 4'hf, ack, err, data);
  endtask

  task automatic expect_ok(input logic ack, input logic err);
    check_val("wb_ack_o", 32'h1, 32'(ack));
    check_val("wb_err_o", 32'h0, 32'(err));
  endtask

  task automatic reg_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic ack;
    logic err;
    wb_write(adr, dat, sel, ack, err);
    expect_ok(ack, err);
  endtask

  task automatic read_check(input logic [31:0] adr, input logic [31:0] exp);
    logic        ack;
    logic        err;
    logic [31:0] data;
    wb_read(adr, ack, err, data);
    expect_ok(ack, err);
    check_val($sformatf("wb_dat_o at %h", adr), exp, data);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    check_val("exit_valid_o", 32'h0, 32'(exit_valid_o));
    check_val("rv_timer_intr_o", 32'h0, 32'(rv_timer_intr_o));
    check_val("intr_gpio_o", 32'h0, 32'(intr_gpio_o));
    check_val("cio_gpio_o", 32'h0, 32'(cio_gpio_o));
    check_val("cio_gpio_en_o", 32'h0, 32'(cio_gpio_en_o));
    for (int i = 0; i < 5; i++) begin
      read_check(reg_addr(i), 32'h0);
    end
  endtask

  task automatic test_readback();
    int          idx;
    logic [31:0] data;
    logic [3:0]  sel;
    for (int i = 0; i < 200; i++) begin
      idx  = int'(rand_bits(3) % 7);
      data = rand_bits(32);
      sel  = 4'(rand_bits(4));
      model[idx] = merge_bytes(model[idx], data, sel) & reg_mask(idx);
      reg_write(reg_addr(idx), data, sel);
      if (idx == 3 || idx == 4) begin
        @(negedge clk_i);
        check_val("cio_gpio_o", model[3], 32'(cio_gpio_o));
        check_val("cio_gpio_en_o", model[4], 32'(cio_gpio_en_o));
      end
      read_check(reg_addr(idx), model[idx]);
    end
  endtask

  task automatic test_unmapped();
    logic [31:0] adr;
    logic        ack;
    logic        err;
    logic [31:0] data;
    for (int i = 0; i < 20; i++) begin
      adr = rand_bits(32);
      if (i % 4 < 2) begin
        // Upper bits clear, only the region field is out of range
        adr = adr & 32'h0000_0fff;
      end
      if (adr < 32'h300) begin
        adr = adr | 32'h300;
      end
      if (i % 2 == 0) begin
        // Scratch offset, so a misrouted write shows in the final read
        adr[7:0] = 8'(REG_SCRATCH);
        wb_write(adr, rand_bits(32), 4'hf, ack, err);
      end else begin
        wb_read(adr, ack, err, data);
        check_val("wb_dat_o", 32'h0, data);
      end
      check_val("wb_ack_o", 32'h0, 32'(ack));
      check_val("wb_err_o", 32'h1, 32'(err));
    end
    read_check(reg_addr(0), model[0]);
  endtask

  task automatic test_soc_ctrl();
    logic        boot;
    logic [31:0] value;
    boot  = lfsr_bit();
    value = rand_bits(32);
    @(posedge clk_i);
    boot_select_i <= boot;
    read_check(SOC_CTRL_BASE + 32'(REG_BOOT_SEL), 32'(boot));
    // Opposite level as well
    @(posedge clk_i);
    boot_select_i <= !boot;
    read_check(SOC_CTRL_BASE + 32'(REG_BOOT_SEL), 32'(!boot));
    model[1] = value;
    reg_write(SOC_CTRL_BASE + 32'(REG_EXIT_VALUE), value, 4'hf);
    reg_write(SOC_CTRL_BASE + 32'(REG_EXIT_VALID), 32'h1, 4'hf);
    @(negedge clk_i);
    check_val("exit_valid_o", 32'h1, 32'(exit_valid_o));
    check_val("exit_value_o", value, exit_value_o);
    read_check(SOC_CTRL_BASE + 32'(REG_EXIT_VALID), 32'h1);
  endtask

  task automatic test_gpio_inputs();
    logic [31:0] pattern;
    logic [31:0] prev;
    logic [31:0] status;
    prev     = '0;
    status   = '0;
    model[5] = rand_bits(32) & GPIO_MASK;
    reg_write(GPIO_BASE + 32'(REG_GIE), model[5], 4'hf);
    for (int i = 0; i < 12; i++) begin
      pattern = rand_bits(NUM_GPIO);
      status  = status | (pattern & ~prev);
      prev    = pattern;
      @(posedge clk_i);
      cio_gpio_i <= pattern[NUM_GPIO-1:0];
      // Two synchroniser flops, then one more edge for the status bit
      repeat (3) @(posedge clk_i);
      read_check(GPIO_BASE + 32'(REG_GIN), pattern);
      read_check(GPIO_BASE + 32'(REG_GIS), status);
      @(negedge clk_i);
      check_val("intr_gpio_o", 32'(|(status & model[5])), 32'(intr_gpio_o));
    end
    reg_write(GPIO_BASE + 32'(REG_GIS), status, 4'hf);
    read_check(GPIO_BASE + 32'(REG_GIS), 32'h0);
    @(negedge clk_i);
    check_val("intr_gpio_o", 32'h0, 32'(intr_gpio_o));
  endtask

  task automatic test_timer();
    logic [31:0] cmp;
    logic [31:0] count;
    int          waited;
    cmp      = 32'd4 + rand_bits(5);
    count    = rand_bits(32);
    model[2] = cmp;
    reg_write(TIMER_BASE + 32'(REG_TCOUNT), 32'h0, 4'hf);
    reg_write(TIMER_BASE + 32'(REG_TCOMPARE), cmp, 4'hf);
    reg_write(TIMER_BASE + 32'(REG_TCTRL), 32'h3, 4'hf);
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!rv_timer_intr_o && waited < int'(cmp) + 4);
    if (!rv_timer_intr_o) begin
      errors++;
      $display("rv_timer_intr_o did not rise within %0d cycles of enabling the timer", cmp + 4);
    end
    // Stop counting before the next match, keep the interrupt enable
    reg_write(TIMER_BASE + 32'(REG_TCTRL), 32'h2, 4'hf);
    read_check(TIMER_BASE + 32'(REG_TSTATUS), 32'h1);
    @(negedge clk_i);
    check_val("rv_timer_intr_o", 32'h1, 32'(rv_timer_intr_o));
    reg_write(TIMER_BASE + 32'(REG_TSTATUS), 32'h1, 4'hf);
    @(negedge clk_i);
    check_val("rv_timer_intr_o", 32'h0, 32'(rv_timer_intr_o));
    reg_write(TIMER_BASE + 32'(REG_TCOUNT), count, 4'hf);
    read_check(TIMER_BASE + 32'(REG_TCOUNT), count);
    read_check(TIMER_BASE + 32'(REG_TCOUNT), count);
  endtask

  initial begin
    lfsr_q          = 32'h4daf093b;
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    errors_at_start = 0;
    for (int i = 0; i < 7; i++) begin
      model[i] = '0;
    end
    rst_n_i       <= 1'b0;
    wb_cyc_i      <= 1'b0;
    wb_stb_i      <= 1'b0;
    wb_we_i       <= 1'b0;
    wb_adr_i      <= '0;
    wb_dat_i      <= '0;
    wb_sel_i      <= '0;
    boot_select_i <= 1'b0;
    cio_gpio_i    <= '0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_reset();
    finish_test("reset state");
    test_readback();
    finish_test("register readback");
    test_unmapped();
    finish_test("unmapped access");
    test_soc_ctrl();
    finish_test("SoC control");
    test_gpio_inputs();
    finish_test("GPIO inputs");
    test_timer();
    finish_test("timer");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog ran out after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

//--- ao_periph.f
source/ao_periph_pkg.sv
source/wb_to_reg.sv
source/reg_demux.sv
source/soc_ctrl.sv
source/ao_timer.sv
source/gpio.sv
source/ao_peripheral_subsystem.sv
sim/tb_ao_peripheral_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_ao_peripheral_subsystem \
  -f ao_periph.f -Mdir obj_dir -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "^all tests passed$" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
